// File: Makefile
VERILATOR ?= verilator
TOP       ?= io_subsystem_tb
OBJ_DIR   ?= obj_dir
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTS PASSED

SOURCES := $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; status=$$?; echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qx "$(PASS_MSG)"; then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// File: bench/io_subsystem_tb.sv
`timescale 1ns/10ps
`include "io_params.svh"

module io_subsystem_tb;

  localparam int CLK_PERIOD = 4;
  localparam int ACK_LAT    = 3; // sampling edge plus two, seen at the next falling edge
  localparam int BUS_LIMIT  = 200;
  localparam int RESET_CYC  = 8;
  localparam int T1_CYCLES  = 400;
  localparam int T2_CYCLES  = 150;
  localparam int T3_CYCLES  = 800;
  localparam int T4_CYCLES  = 1600;
  localparam int T5_CYCLES  = 600;
  localparam int MARGIN     = 1000;
  localparam int RUN_CYCLES = RESET_CYC + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES +
                              T5_CYCLES + MARGIN;

  logic                 clk = 1'b0;
  logic                 reset;
  io_bus_pkg::wb_req_t  bus_req;
  io_bus_pkg::wb_rsp_t  bus_rsp;
  logic                 button1;
  logic                 button2;
  logic                 led;
  logic [4:0]           dac1_code;
  logic [4:0]           dac2_code;
  logic                 sck;
  logic                 mosi;
  logic                 ncs;
  logic                 dc;
  io_dev_pkg::irq_vec_t irq;

  int         errors = 0;
  int         checks = 0;
  int         cycle = 0;
  int         req_cycle = 0;
  logic [2:0] m_port;
  logic [4:0] m_dac1;
  logic [4:0] m_dac2;
  logic [7:0] m_irq;
  logic [8:0] exp_q[$]; // words written to the lcd
  logic [8:0] rx_q[$];  // words seen on the spi pins

  logic       sck_prev = 1'b0;
  logic       ncs_prev = 1'b1;
  logic       word_dc;
  logic [7:0] spi_shift;
  int         nbits = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  io_subsystem io_subsystem_inst (
    .clk       (clk),
    .reset     (reset),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .button1   (button1),
    .button2   (button2),
    .led       (led),
    .dac1_code (dac1_code),
    .dac2_code (dac2_code),
    .sck       (sck),
    .mosi      (mosi),
    .ncs       (ncs),
    .dc        (dc),
    .irq       (irq)
  );

  task automatic expect_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  task automatic flag_problem(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  // one wishbone classic cycle, started and ended on a falling edge
  task automatic bus_cycle(input logic we, input logic [2:0] sel, input logic [31:0] wdat,
                           output logic [31:0] rdat, output logic got_ack,
                           output logic got_err, output int lat);
    lat = 0;
    @(negedge clk);
    bus_req.cyc = 1'b1;
    bus_req.stb = 1'b1;
    bus_req.we  = we;
    bus_req.adr = {sel, 29'($urandom)}; // low bits are not decoded
    bus_req.dat = wdat;
    req_cycle   = cycle;
    do begin
      @(negedge clk);
      lat++;
    end while (!bus_rsp.ack && !bus_rsp.err && lat < BUS_LIMIT);
    got_ack = bus_rsp.ack;
    got_err = bus_rsp.err;
    rdat    = bus_rsp.dat;
    if (!got_ack && !got_err) flag_problem("bus cycle got neither ack nor err, slave hung");
    bus_req.cyc = 1'b0;
    bus_req.stb = 1'b0;
  endtask

  task automatic write_word(input logic [2:0] sel, input logic [31:0] data, output int lat);
    logic [31:0] rdat;
    logic        got_ack;
    logic        got_err;
    bus_cycle(1'b1, sel, data, rdat, got_ack, got_err, lat);
    expect_value("bus_rsp.ack", 32'd1, 32'(got_ack));
  endtask

  task automatic read_word(input logic [2:0] sel, output logic [31:0] data, output int lat);
    logic got_ack;
    logic got_err;
    bus_cycle(1'b0, sel, 32'd0, data, got_ack, got_err, lat);
    expect_value("bus_rsp.ack", 32'd1, 32'(got_ack));
  endtask

  function automatic logic [31:0] model_reg(input logic [2:0] sel);
    case (sel)
      io_dev_pkg::DEV_PORT: return {29'd0, m_port};
      io_dev_pkg::DEV_DAC1: return {27'd0, m_dac1};
      default:              return {27'd0, m_dac2};
    endcase
  endfunction

  function automatic logic [2:0] pick_reg(input int k);
    if (k == 0) return io_dev_pkg::DEV_PORT;
    if (k == 1) return io_dev_pkg::DEV_DAC1;
    return io_dev_pkg::DEV_DAC2;
  endfunction

  task automatic wait_lcd_idle();
    logic [31:0] rdat;
    int          lat;
    int          polls;
    polls = 0;
    do begin
      read_word(io_dev_pkg::DEV_STATUS, rdat, lat);
      polls++;
    end while (!rdat[1] && polls < 400);
    if (!rdat[1]) flag_problem("lcd_done never rose after the last lcd word");
  endtask

  task automatic check_spi_words();
    logic [8:0] exp;
    logic [8:0] got;
    if (rx_q.size() != exp_q.size()) flag_problem("spi word count differs from words written");
    while (exp_q.size() > 0 && rx_q.size() > 0) begin
      exp = exp_q.pop_front();
      got = rx_q.pop_front();
      expect_value("spi word {dc, data}", 32'(exp), 32'(got));
    end
    exp_q.delete();
    rx_q.delete();
  endtask

  // bits are taken on rising sck, seen at the following falling clk edge
  always @(negedge clk) begin
    if (!reset) begin
      if (!ncs && sck && !sck_prev) begin
        if (nbits == 8) begin
          flag_problem("ncs stayed low between two spi words");
          nbits = 0;
        end
        if (nbits == 0) word_dc = dc;
        else if (dc !== word_dc) flag_problem("dc changed while ncs was low");
        spi_shift = {spi_shift[6:0], mosi};
        nbits++;
        if (nbits == 8) rx_q.push_back({word_dc, spi_shift});
      end
      if (ncs && !ncs_prev) begin
        if (nbits != 8) flag_problem("ncs rose in the middle of an spi word");
        nbits = 0;
      end
    end
    sck_prev = sck;
    ncs_prev = ncs;
  end

  task automatic test_registers();
    int          lat;
    logic [2:0]  sel;
    logic [31:0] data;
    logic [31:0] rdat;
    for (int i = 0; i < 12; i++) begin
      sel  = pick_reg($urandom_range(2, 0));
      data = $urandom;
      write_word(sel, data, lat);
      expect_value("write ack latency", ACK_LAT, lat);
      if (sel == io_dev_pkg::DEV_PORT) m_port = data[2:0];
      else if (sel == io_dev_pkg::DEV_DAC1) m_dac1 = data[4:0];
      else m_dac2 = data[4:0];
      expect_value("led", 32'(m_port[0]), 32'(led));
      expect_value("dac1_code", 32'(m_dac1), 32'(dac1_code));
      expect_value("dac2_code", 32'(m_dac2), 32'(dac2_code));
      sel = pick_reg($urandom_range(2, 0));
      read_word(sel, rdat, lat);
      expect_value("bus_rsp.dat", model_reg(sel), rdat);
      expect_value("read ack latency", ACK_LAT, lat);
    end
  endtask

  task automatic test_status();
    int          lat;
    logic [31:0] rdat;
    logic        got_ack;
    logic        got_err;
    bus_cycle(1'b0, io_dev_pkg::DEV_UNMAPPED, 32'd0, rdat, got_ack, got_err, lat);
    expect_value("bus_rsp.err", 32'd1, 32'(got_err));
    expect_value("bus_rsp.ack", 32'd0, 32'(got_ack));
    expect_value("err latency", ACK_LAT, lat);
    for (int i = 0; i < 4; i++) begin
      button1 = 1'($urandom);
      button2 = 1'($urandom);
      read_word(io_dev_pkg::DEV_STATUS, rdat, lat);
      expect_value("status", {28'd0, button1, button2, 1'b1, 1'b0}, rdat); // lcd idle
    end
  endtask

  task automatic test_lcd_stream();
    int         lat;
    int         n;
    logic [8:0] word;
    n = $urandom_range(8, 4);
    for (int i = 0; i < n; i++) begin
      word = 9'($urandom); // bit 8 is dc
      exp_q.push_back(word);
      write_word(io_dev_pkg::DEV_LCD, {23'd0, word}, lat);
    end
    wait_lcd_idle();
    check_spi_words();
    expect_value("ncs", 32'd1, 32'(ncs));
  endtask

  task automatic test_lcd_backpressure();
    int          lat;
    int          max_lat;
    logic [8:0]  word;
    logic [31:0] rdat;
    max_lat = 0;
    for (int i = 0; i < `LCD_FIFO_DEPTH + 6; i++) begin
      word = 9'($urandom);
      exp_q.push_back(word);
      write_word(io_dev_pkg::DEV_LCD, {23'd0, word}, lat);
      if (lat > max_lat) max_lat = lat;
    end
    if (max_lat <= ACK_LAT) flag_problem("lcd burst never stalled on a full fifo");
    read_word(io_dev_pkg::DEV_STATUS, rdat, lat);
    expect_value("status.lcd_fifo_full", 32'd1, 32'(rdat[0]));
    expect_value("status.lcd_done", 32'd0, 32'(rdat[1]));
    wait_lcd_idle();
    check_spi_words();
  endtask

  task automatic test_interrupts();
    int          lat;
    int          n;
    int          waited;
    int          elapsed;
    logic [8:0]  word;
    logic [31:0] rdat;
    write_word(io_dev_pkg::DEV_IRQ, 32'hff, lat); // drop edges left by the lcd tests
    m_irq = 8'h00;
    read_word(io_dev_pkg::DEV_IRQ, rdat, lat);
    expect_value("irq register", 32'(m_irq), rdat);
    n = $urandom_range(12, 1);
    write_word(io_dev_pkg::DEV_TIMER, 32'(n), lat);
    waited = 0;
    while (!irq[0] && waited < n * `TIMER_TICK_DIV + 40) begin
      @(negedge clk);
      waited++;
    end
    elapsed = cycle - req_cycle;
    if (!irq[0]) flag_problem("timer interrupt never came");
    else if (elapsed < n * `TIMER_TICK_DIV || elapsed > n * `TIMER_TICK_DIV + 8)
      flag_problem($sformatf("timer interrupt after %0d cycles for a load of %0d", elapsed, n));
    m_irq[0] = 1'b1;
    expect_value("irq", 32'(m_irq), 32'(irq));
    read_word(io_dev_pkg::DEV_TIMER, rdat, lat);
    expect_value("timer count", 32'd0, rdat);
    write_word(io_dev_pkg::DEV_IRQ, 32'h1, lat);
    m_irq[0] = 1'b0;
    read_word(io_dev_pkg::DEV_IRQ, rdat, lat);
    expect_value("irq register", 32'(m_irq), rdat);
    word = 9'($urandom);
    exp_q.push_back(word);
    write_word(io_dev_pkg::DEV_LCD, {23'd0, word}, lat);
    waited = 0;
    while (!irq[1] && waited < 300) begin
      @(negedge clk);
      waited++;
    end
    if (!irq[1]) flag_problem("lcd done edge did not raise its interrupt");
    m_irq[1] = 1'b1;
    read_word(io_dev_pkg::DEV_IRQ, rdat, lat);
    expect_value("irq register", 32'(m_irq), rdat);
    write_word(io_dev_pkg::DEV_IRQ, 32'h2, lat);
    m_irq[1] = 1'b0;
    read_word(io_dev_pkg::DEV_IRQ, rdat, lat);
    expect_value("irq register", 32'(m_irq), rdat);
    expect_value("irq", 32'(m_irq), 32'(irq));
    check_spi_words();
  endtask

  task automatic report_test(input int num, input string name, input int start_errors);
    $display("test %0d %s: %0d errors", num, name, errors - start_errors);
  endtask

  initial begin
    int start;
    void'($urandom(32'hf530_aa43));
    reset   = 1'b1;
    bus_req = '0;
    button1 = 1'b0;
    button2 = 1'b0;
    m_port  = '0;
    m_dac1  = '0;
    m_dac2  = '0;
    m_irq   = '0;
    repeat (RESET_CYC) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    start = errors;
    expect_value("bus_rsp.ack", 32'd0, 32'(bus_rsp.ack));
    expect_value("bus_rsp.err", 32'd0, 32'(bus_rsp.err));
    expect_value("irq", 32'd0, 32'(irq));
    expect_value("ncs", 32'd1, 32'(ncs));
    expect_value("sck", 32'd0, 32'(sck));
    expect_value("led", 32'd0, 32'(led));
    expect_value("dac1_code", 32'd0, 32'(dac1_code));
    expect_value("dac2_code", 32'd0, 32'(dac2_code));
    test_registers();
    report_test(1, "port and dac registers", start);
    start = errors;
    test_status();
    report_test(2, "unmapped error and status", start);
    start = errors;
    test_lcd_stream();
    report_test(3, "lcd word stream", start);
    start = errors;
    test_lcd_backpressure();
    report_test(4, "lcd fifo back-pressure", start);
    start = errors;
    test_interrupts();
    report_test(5, "timer and interrupts", start);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not finish", RUN_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: flist.f
+incdir+rtl
rtl/io_bus_pkg.sv
rtl/io_dev_pkg.sv
rtl/io_decode.sv
rtl/io_regs.sv
rtl/spi_lcd_tx.sv
rtl/interval_timer.sv
rtl/irq_ctrl.sv
rtl/io_result.sv
rtl/io_subsystem.sv
bench/io_subsystem_tb.sv

// File: rtl/interval_timer.sv
`timescale 1ns/10ps
`include "io_params.svh"

module interval_timer (
  input  logic                 clk,
  input  logic                 reset,
  input  io_dev_pkg::dev_cmd_t cmd,
  input  logic                 hit,
  output logic                 event_pulse,
  output logic [31:0]          count
);

  localparam int DIV   = `TIMER_TICK_DIV;
  localparam int PRE_W = $clog2(DIV + 1);

  logic [PRE_W-1:0] prescale;
  logic             tick;
  logic             load;

  assign load = cmd.valid && hit && cmd.we;
  assign tick = prescale == PRE_W'(DIV - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      prescale    <= '0;
      count       <= 32'd0;
      event_pulse <= 1'b0;
    end else begin
      event_pulse <= 1'b0;
      if (load) begin
        count    <= cmd.wdata; // zero stops the timer
        prescale <= '0;
      end else if (count != 32'd0) begin
        if (tick) begin
          prescale <= '0;
          count    <= count - 1'b1;
          if (count == 32'd1) begin
            event_pulse <= 1'b1;
          end
        end else begin
          prescale <= prescale + 1'b1;
        end
      end
    end
  end

endmodule

// File: rtl/io_bus_pkg.sv
package io_bus_pkg;

  // wishbone classic, master side
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
  } wb_req_t;

  // wishbone classic, slave side
  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

// File: rtl/io_decode.sv
`timescale 1ns/10ps
`include "io_params.svh"

module io_decode (
  input  logic                 clk,
  input  logic                 reset,
  input  io_bus_pkg::wb_req_t  bus_req,
  input  logic                 rsp_done,
  output io_dev_pkg::dev_cmd_t cmd,
  output logic [7:0]           dev_hit
);

  logic req;
  logic busy; // cycle taken, waiting for stb to drop
  logic take;

  assign req  = bus_req.cyc && bus_req.stb;
  assign take = !cmd.valid && !busy && req;

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd.valid <= 1'b0;
      busy      <= 1'b0;
    end else begin
      if (cmd.valid && rsp_done) begin
        cmd.valid <= 1'b0;
      end else if (take) begin
        cmd.valid <= 1'b1;
        busy      <= 1'b1;
      end
      if (busy && !cmd.valid && !req) begin
        busy <= 1'b0;
      end
    end
    if (take) begin
      cmd.we    <= bus_req.we;
      cmd.sel   <= io_dev_pkg::dev_sel_e'(bus_req.adr[`IO_SEL_MSB:`IO_SEL_LSB]);
      cmd.wdata <= bus_req.dat;
    end
  end

  assign dev_hit = 8'd1 << cmd.sel;

  // held command must not move until the response retires it
  assert property (@(posedge clk) disable iff (reset)
    (cmd.valid && !rsp_done) |=> $stable(cmd));

endmodule

// File: rtl/io_dev_pkg.sv
package io_dev_pkg;

  // device number from the top address bits
  typedef enum logic [2:0] {
    DEV_PORT     = 3'd0,
    DEV_LCD      = 3'd1,
    DEV_TIMER    = 3'd2,
    DEV_DAC1     = 3'd3,
    DEV_DAC2     = 3'd4,
    DEV_STATUS   = 3'd5,
    DEV_IRQ      = 3'd6,
    DEV_UNMAPPED = 3'd7
  } dev_sel_e;

  typedef struct packed {
    logic        valid;
    logic        we;
    dev_sel_e    sel;
    logic [31:0] wdata;
  } dev_cmd_t;

  // status word bits 3..0
  typedef struct packed {
    logic button1;
    logic button2;
    logic lcd_done;
    logic lcd_fifo_full;
  } dev_status_t;

  typedef logic [7:0] irq_vec_t; // bit 0 timer, bit 1 lcd done

endpackage

// File: rtl/io_params.svh
`ifndef IO_PARAMS_SVH
`define IO_PARAMS_SVH

// device select field of the bus address
`define IO_SEL_MSB 31
`define IO_SEL_LSB 29

// words held by the lcd queue
`define LCD_FIFO_DEPTH 16

// clk cycles per half sck period
`define SPI_CLK_DIV 2

// clk cycles per timer tick, short for simulation
`define TIMER_TICK_DIV 8

`endif

// File: rtl/io_regs.sv
`timescale 1ns/10ps

module io_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  io_dev_pkg::dev_cmd_t cmd,
  input  logic [7:0]           dev_hit,
  output logic                 led,
  output logic                 lcd_reset,
  output logic                 timer_gate,
  output logic [4:0]           dac1_code,
  output logic [4:0]           dac2_code,
  output logic [2:0]           port_value
);

  logic wr;

  assign wr = cmd.valid && cmd.we;

  always_ff @(posedge clk) begin
    if (reset) begin
      led        <= 1'b0;
      lcd_reset  <= 1'b0;
      timer_gate <= 1'b0;
    end else if (wr && dev_hit[io_dev_pkg::DEV_PORT]) begin
      {timer_gate, lcd_reset, led} <= cmd.wdata[2:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dac1_code <= 5'd0;
    end else if (wr && dev_hit[io_dev_pkg::DEV_DAC1]) begin
      dac1_code <= cmd.wdata[4:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dac2_code <= 5'd0;
    end else if (wr && dev_hit[io_dev_pkg::DEV_DAC2]) begin
      dac2_code <= cmd.wdata[4:0];
    end
  end

  assign port_value = {timer_gate, lcd_reset, led}; // read back

endmodule

// File: rtl/io_result.sv
`timescale 1ns/10ps

module io_result (
  input  logic                    clk,
  input  logic                    reset,
  input  io_dev_pkg::dev_cmd_t    cmd,
  input  logic                    lcd_accept,
  input  logic [2:0]              port_value,
  input  logic [4:0]              dac1_code,
  input  logic [4:0]              dac2_code,
  input  logic [31:0]             timer_count,
  input  io_dev_pkg::irq_vec_t    irq,
  input  io_dev_pkg::dev_status_t status,
  output io_bus_pkg::wb_rsp_t     bus_rsp,
  output logic                    rsp_done
);

  logic        accept;
  logic        go;
  logic        go_err;
  logic [31:0] rdata;
  logic [31:0] rdata_q;

  always_comb begin
    case (cmd.sel)
      io_dev_pkg::DEV_PORT:   rdata = {29'd0, port_value};
      io_dev_pkg::DEV_TIMER:  rdata = timer_count;
      io_dev_pkg::DEV_DAC1:   rdata = {27'd0, dac1_code};
      io_dev_pkg::DEV_DAC2:   rdata = {27'd0, dac2_code};
      io_dev_pkg::DEV_STATUS: rdata = 32'(status);
      io_dev_pkg::DEV_IRQ:    rdata = 32'(irq);
      default:                rdata = 32'd0;
    endcase
  end

  // only the lcd can hold off a command
  assign accept   = (cmd.sel == io_dev_pkg::DEV_LCD) ? lcd_accept : 1'b1;
  assign rsp_done = cmd.valid && accept;

  always_ff @(posedge clk) begin
    if (reset) begin
      go          <= 1'b0;
      bus_rsp.ack <= 1'b0;
      bus_rsp.err <= 1'b0;
    end else begin
      go          <= rsp_done;
      bus_rsp.ack <= go && !go_err;
      bus_rsp.err <= go && go_err;
    end
    if (rsp_done) begin
      go_err  <= cmd.sel == io_dev_pkg::DEV_UNMAPPED;
      rdata_q <= rdata; // value at the accept edge
    end
    bus_rsp.dat <= rdata_q;
  end

  // single cycle response, ack and err exclusive
  assert property (@(posedge clk) disable iff (reset)
    (bus_rsp.ack || bus_rsp.err) |->
      !(bus_rsp.ack && bus_rsp.err) ##1 !(bus_rsp.ack || bus_rsp.err));

endmodule

// File: rtl/io_subsystem.sv
`timescale 1ns/10ps

module io_subsystem (
  input  logic                 clk,
  input  logic                 reset,
  input  io_bus_pkg::wb_req_t  bus_req,
  output io_bus_pkg::wb_rsp_t  bus_rsp,
  input  logic                 button1,
  input  logic                 button2,
  output logic                 led,
  output logic [4:0]           dac1_code,
  output logic [4:0]           dac2_code,
  output logic                 sck,
  output logic                 mosi,
  output logic                 ncs,
  output logic                 dc,
  output io_dev_pkg::irq_vec_t irq
);

  io_dev_pkg::dev_cmd_t cmd;
  logic [7:0]           dev_hit;
  logic                 rsp_done;
  logic                 lcd_accept;
  logic                 lcd_fifo_full;
  logic                 lcd_done;
  logic                 timer_event;
  logic [31:0]          timer_count;
  logic [2:0]           port_value;

  io_decode io_decode_inst (
    .clk      (clk),
    .reset    (reset),
    .bus_req  (bus_req),
    .rsp_done (rsp_done),
    .cmd      (cmd),
    .dev_hit  (dev_hit)
  );

  // lcd_reset and timer_gate only reach the outside through port reads
  io_regs io_regs_inst (
    .clk        (clk),
    .reset      (reset),
    .cmd        (cmd),
    .dev_hit    (dev_hit),
    .led        (led),
    .lcd_reset  (),
    .timer_gate (),
    .dac1_code  (dac1_code),
    .dac2_code  (dac2_code),
    .port_value (port_value)
  );

  spi_lcd_tx spi_lcd_tx_inst (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .hit       (dev_hit[io_dev_pkg::DEV_LCD]),
    .accept    (lcd_accept),
    .fifo_full (lcd_fifo_full),
    .done      (lcd_done),
    .sck       (sck),
    .mosi      (mosi),
    .ncs       (ncs),
    .dc        (dc)
  );

  interval_timer interval_timer_inst (
    .clk         (clk),
    .reset       (reset),
    .cmd         (cmd),
    .hit         (dev_hit[io_dev_pkg::DEV_TIMER]),
    .event_pulse (timer_event),
    .count       (timer_count)
  );

  irq_ctrl irq_ctrl_inst (
    .clk     (clk),
    .reset   (reset),
    .cmd     (cmd),
    .hit     (dev_hit[io_dev_pkg::DEV_IRQ]),
    .sources ({6'd0, lcd_done, timer_event}),
    .irq     (irq)
  );

  io_result io_result_inst (
    .clk         (clk),
    .reset       (reset),
    .cmd         (cmd),
    .lcd_accept  (lcd_accept),
    .port_value  (port_value),
    .dac1_code   (dac1_code),
    .dac2_code   (dac2_code),
    .timer_count (timer_count),
    .irq         (irq),
    .status      ({button1, button2, lcd_done, lcd_fifo_full}),
    .bus_rsp     (bus_rsp),
    .rsp_done    (rsp_done)
  );

endmodule

// File: rtl/irq_ctrl.sv
`timescale 1ns/10ps

module irq_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  io_dev_pkg::dev_cmd_t cmd,
  input  logic                 hit,
  input  io_dev_pkg::irq_vec_t sources,
  output io_dev_pkg::irq_vec_t irq
);

  io_dev_pkg::irq_vec_t src_q;
  io_dev_pkg::irq_vec_t rise;
  io_dev_pkg::irq_vec_t clear;

  assign rise  = sources & ~src_q;
  assign clear = (cmd.valid && hit && cmd.we) ? cmd.wdata[7:0] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      src_q <= '1; // a source already high at reset is not an edge
      irq   <= '0;
    end else begin
      src_q <= sources;
      irq   <= (irq & ~clear) | rise; // new edge wins over clear
    end
  end

  // pending bit only appears after a low to high step on its source
  assert property (@(posedge clk) disable iff (reset)
    ((irq & ~$past(irq)) & ~($past(sources) & ~$past(sources, 2))) == '0);

endmodule

// File: rtl/spi_lcd_tx.sv
`timescale 1ns/10ps
`include "io_params.svh"

module spi_lcd_tx (
  input  logic                 clk,
  input  logic                 reset,
  input  io_dev_pkg::dev_cmd_t cmd,
  input  logic                 hit,
  output logic                 accept,
  output logic                 fifo_full,
  output logic                 done,
  output logic                 sck,
  output logic                 mosi,
  output logic                 ncs,
  output logic                 dc
);

  localparam int DEPTH = `LCD_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int DIV   = `SPI_CLK_DIV;
  localparam int DIV_W = $clog2(DIV + 1);

  logic [8:0]       mem [DEPTH]; // dc + data byte
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             empty;
  logic             push;
  logic             pop;
  logic             busy;
  logic             half_end;
  logic [7:0]       shift_q;
  logic [2:0]       bit_cnt;
  logic [DIV_W-1:0] div_cnt;

  assign empty     = count == '0;
  assign fifo_full = count == (PTR_W + 1)'(DEPTH);
  assign accept    = !(cmd.we && fifo_full); // stall writes only
  assign push      = cmd.valid && hit && cmd.we && !fifo_full;
  assign pop       = !busy && !empty;
  assign done      = empty && !busy;
  assign half_end  = busy && div_cnt == DIV_W'(DIV - 1);
  assign mosi      = shift_q[7];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= cmd.wdata[8:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  // mode 0, data sampled on rising sck
  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      ncs     <= 1'b1;
      sck     <= 1'b0;
      bit_cnt <= 3'd0;
      div_cnt <= '0;
    end else if (pop) begin
      busy    <= 1'b1;
      ncs     <= 1'b0;
      bit_cnt <= 3'd7;
      div_cnt <= '0;
    end else if (half_end) begin
      div_cnt <= '0;
      sck     <= !sck;
      if (sck && bit_cnt == 3'd0) begin
        busy <= 1'b0; // ncs rises with the last falling sck
        ncs  <= 1'b1;
      end else if (sck) begin
        bit_cnt <= bit_cnt - 1'b1;
      end
    end else if (busy) begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      shift_q <= mem[rd_ptr][7:0];
      dc      <= mem[rd_ptr][8];
    end else if (half_end && sck) begin
      shift_q <= shift_q << 1;
    end
  end

  // a full queue with nothing leaving stays full, so no write got in
  assert property (@(posedge clk) disable iff (reset)
    (fifo_full && !pop) |=> fifo_full);

endmodule
